// ==== Bender.yml ====
package:
  name: bpu_btb

sources:
  - rtl/isa_pkg.sv
  - rtl/btb_pkg.sv
  - rtl/sdpram.sv
  - rtl/btb_lookup_gen.sv
  - rtl/btb_bank.sv
  - rtl/btb_bank_select.sv
  - rtl/bpu_btb_top.sv
  - target: simulation
    files:
      - verif/tb_bpu_btb.sv

// ==== rtl/bpu_btb_top.sv ====
`timescale 1ns/1ns

module bpu_btb_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              update_i,
    input  isa_pkg::br_type_e br_type_i,
    input  isa_pkg::pc_t      rpc_i,
    input  isa_pkg::pc_t      wpc_i,
    input  isa_pkg::pc_t      bta_i,
    output logic              miss_o,
    output btb_pkg::choice_t  choice_o,
    output isa_pkg::br_type_e br_type_o,
    output isa_pkg::pc_t      bta_o
);

    btb_pkg::btb_addr_t                          rd_addr;
    btb_pkg::btb_addr_t                          wr_addr;
    btb_pkg::btb_addr_t                          pre_addr;
    isa_pkg::pc_t                                pre_pc;
    btb_pkg::btb_entry_t                         wr_entry;
    btb_pkg::btb_entry_t [btb_pkg::NUM_BANKS-1:0] bank_entries;
    logic [btb_pkg::NUM_BANKS-1:0]               bank_valids;

    // ------------------------------------------------------------
    // Address generation
    // ------------------------------------------------------------

    btb_lookup_gen u_lookup (
        .clk        (clk),
        .rst_n      (rst_n),
        .rpc_i      (rpc_i),
        .wpc_i      (wpc_i),
        .rd_addr_o  (rd_addr),
        .wr_addr_o  (wr_addr),
        .pre_addr_o (pre_addr),
        .pre_pc_o   (pre_pc)
    );

    // Entry from the resolve stage, slot taken from the write PC
    assign wr_entry.choice  = wpc_i[btb_pkg::OFFSET_W-1:isa_pkg::PC_LSB];
    assign wr_entry.tag     = wr_addr.tag;
    assign wr_entry.bta     = bta_i;
    assign wr_entry.br_type = br_type_i;

    // ------------------------------------------------------------
    // Banks
    // ------------------------------------------------------------

    for (genvar k = 0; k < btb_pkg::NUM_BANKS; k++) begin : g_bank
        logic bank_we;

        // Only the bank named by the write PC takes the update
        assign bank_we = update_i && (wr_addr.bank == btb_pkg::bank_t'(k));

        btb_bank u_bank (
            .clk     (clk),
            .rst_n   (rst_n),
            .we_i    (bank_we),
            .raddr_i (rd_addr.index),
            .waddr_i (wr_addr.index),
            .din_i   (wr_entry),
            .dout_o  (bank_entries[k]),
            .valid_o (bank_valids[k])
        );
    end

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------

    btb_bank_select u_select (
        .entries_i  (bank_entries),
        .valids_i   (bank_valids),
        .pre_addr_i (pre_addr),
        .pre_pc_i   (pre_pc),
        .miss_o     (miss_o),
        .choice_o   (choice_o),
        .br_type_o  (br_type_o),
        .bta_o      (bta_o)
    );

endmodule : bpu_btb_top

// ==== rtl/btb_bank.sv ====
`timescale 1ns/1ns

module btb_bank (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we_i,
    input  btb_pkg::index_t     raddr_i,
    input  btb_pkg::index_t     waddr_i,
    input  btb_pkg::btb_entry_t din_i,
    output btb_pkg::btb_entry_t dout_o,
    output logic                valid_o
);

    // ------------------------------------------------------------
    // Entry RAM
    // ------------------------------------------------------------

    // Always enabled, a new lookup every cycle
    sdpram #(
        .ADDR_WIDTH (btb_pkg::INDEX_W),
        .DATA_WIDTH ($bits(btb_pkg::btb_entry_t))
    ) u_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (1'b1),
        .we_i    (we_i),
        .raddr_i (raddr_i),
        .waddr_i (waddr_i),
        .din_i   (din_i),
        .dout_o  (dout_o)
    );

    // ------------------------------------------------------------
    // Valid flags
    // ------------------------------------------------------------

    // One flag per entry, all clear after reset
    logic [btb_pkg::BANK_DEPTH-1:0] valid_q;

    // Set on write, never cleared except by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[waddr_i] <= 1'b1;
        end
    end

    // Registered next to the RAM read, same read-first behavior
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_q[raddr_i];
        end
    end

    // Write strobe must be clean once out of reset
    we_known_a: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(we_i))
        else $error("btb_bank: write strobe unknown");

endmodule : btb_bank

// ==== rtl/btb_bank_select.sv ====
`timescale 1ns/1ns

module btb_bank_select (
    input  btb_pkg::btb_entry_t [btb_pkg::NUM_BANKS-1:0] entries_i,
    input  logic [btb_pkg::NUM_BANKS-1:0]                valids_i,
    input  btb_pkg::btb_addr_t                           pre_addr_i,
    input  isa_pkg::pc_t                                 pre_pc_i,
    output logic                                         miss_o,
    output btb_pkg::choice_t                             choice_o,
    output isa_pkg::br_type_e                            br_type_o,
    output isa_pkg::pc_t                                 bta_o
);

    btb_pkg::btb_entry_t                        sel_entry;
    logic                                       sel_valid;
    logic                                       hit;
    logic [isa_pkg::PC_MSB:btb_pkg::OFFSET_W]   next_block;
    isa_pkg::pc_t                               fallback_bta;

    // ------------------------------------------------------------
    // Bank pick and tag compare
    // ------------------------------------------------------------

    // Bank bit of the delayed read PC names the bank
    assign sel_entry = entries_i[pre_addr_i.bank];
    assign sel_valid = valids_i[pre_addr_i.bank];

    // Hit needs a written entry and a matching hashed tag
    assign hit = sel_valid && (sel_entry.tag == pre_addr_i.tag);

    // ------------------------------------------------------------
    // Fallback target
    // ------------------------------------------------------------

    // Block number of the read PC, plus one block
    assign next_block = pre_pc_i[isa_pkg::PC_MSB:btb_pkg::OFFSET_W] + 1'b1;
    // Slot bits zero, start of the next sequential block
    assign fallback_bta = {next_block, {btb_pkg::CHOICE_W{1'b0}}};

    // ------------------------------------------------------------
    // Prediction
    // ------------------------------------------------------------

    assign miss_o    = !hit;
    // Slot 0 on a miss, the whole block falls through
    assign choice_o  = hit ? sel_entry.choice : '0;
    assign br_type_o = hit ? sel_entry.br_type : isa_pkg::BR_PC_RELATIVE;
    assign bta_o     = hit ? sel_entry.bta : fallback_bta;

    // Stored target of a hit was written from a real update
    // Unknown here means RAM data and valid flag went out of step
    always_comb begin
        bta_known_on_hit_a: assert final ($isunknown(hit) || !hit || !$isunknown(bta_o))
            else $error("btb_bank_select: hit with unknown target");
    end

endmodule : btb_bank_select

// ==== rtl/btb_lookup_gen.sv ====
`timescale 1ns/1ns

module btb_lookup_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::pc_t       rpc_i,
    input  isa_pkg::pc_t       wpc_i,
    output btb_pkg::btb_addr_t rd_addr_o,
    output btb_pkg::btb_addr_t wr_addr_o,
    output btb_pkg::btb_addr_t pre_addr_o,
    output isa_pkg::pc_t       pre_pc_o
);

    // ------------------------------------------------------------
    // Hash and field slicing
    // ------------------------------------------------------------

    // Fold upper PC bits onto the bits right above the block offset
    // Upper half PC[31:17], lower half PC[17:3]
    function automatic btb_pkg::tag_t hash_tag(isa_pkg::pc_t pc);
        return pc[isa_pkg::PC_MSB -: btb_pkg::TAG_W]
             ^ pc[btb_pkg::OFFSET_W +: btb_pkg::TAG_W];
    endfunction

    // Bank PC[9], index PC[8:3], slot and word bits dropped
    function automatic btb_pkg::btb_addr_t split_pc(isa_pkg::pc_t pc);
        btb_pkg::btb_addr_t addr;
        addr.bank  = pc[btb_pkg::OFFSET_W + btb_pkg::INDEX_W +: btb_pkg::BANK_W];
        addr.index = pc[btb_pkg::OFFSET_W +: btb_pkg::INDEX_W];
        addr.tag   = hash_tag(pc);
        return addr;
    endfunction

    // ------------------------------------------------------------
    // Read and write side, same cycle
    // ------------------------------------------------------------

    // Read address goes straight to the RAMs
    assign rd_addr_o = split_pc(rpc_i);
    // Write address for the resolve-stage update
    assign wr_addr_o = split_pc(wpc_i);

    // ------------------------------------------------------------
    // Delayed read PC
    // ------------------------------------------------------------

    isa_pkg::pc_t pre_pc_q;

    // Lines up with the registered RAM output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_pc_q <= '0;
        end else begin
            pre_pc_q <= rpc_i;
        end
    end

    // Fields re-derived for the tag compare and bank pick
    assign pre_addr_o = split_pc(pre_pc_q);
    assign pre_pc_o   = pre_pc_q;

endmodule : btb_lookup_gen

// ==== rtl/btb_pkg.sv ====
package btb_pkg;

    // ------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------

    // Instructions per fetch block
    localparam int BLOCK_SIZE = 2;
    // Slot number inside the block
    localparam int CHOICE_W   = $clog2(BLOCK_SIZE);
    // Word bits plus slot bits, everything below the index
    localparam int OFFSET_W   = CHOICE_W + isa_pkg::PC_LSB;
    // Index per bank, PC[8:3]
    localparam int INDEX_W    = 6;
    localparam int BANK_DEPTH = 1 << INDEX_W;
    // Bank select is the PC bit right above the index
    localparam int NUM_BANKS  = 2;
    localparam int BANK_W     = $clog2(NUM_BANKS);
    // Hashed tag, PC[31:17] ^ PC[17:3]
    localparam int TAG_W      = 15;

    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [BANK_W-1:0]   bank_t;
    typedef logic [CHOICE_W-1:0] choice_t;

    // ------------------------------------------------------------
    // Stored entry and derived address
    // ------------------------------------------------------------

    // 48 bits, valid flag is kept beside the RAM
    typedef struct packed {
        choice_t              choice;
        tag_t                 tag;
        isa_pkg::pc_t         bta;
        isa_pkg::br_type_e    br_type;
    } btb_entry_t;

    // 22 bits, one per PC that enters the BTB
    typedef struct packed {
        bank_t  bank;
        index_t index;
        tag_t   tag;
    } btb_addr_t;

endpackage : btb_pkg

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    // ------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------

    // Word-aligned fetch address, byte offset bits dropped
    localparam int PC_MSB = 31;
    localparam int PC_LSB = 2;

    // Bits 31 down to 2, 30 bits in all
    typedef logic [PC_MSB:PC_LSB] pc_t;

    // ------------------------------------------------------------
    // Branch classification
    // ------------------------------------------------------------

    // Encoding shared by decode, BTB and resolve stage
    // PC-relative doubles as the fallback type on a BTB miss
    typedef enum logic [1:0] {
        // Conditional or direct jump, target from PC plus offset
        BR_PC_RELATIVE = 2'b00,
        // Register-indirect jump
        BR_ABSOLUTE    = 2'b01,
        // Call, pushes the return address
        BR_CALL        = 2'b10,
        // Return, pops the return address
        BR_RETURN      = 2'b11
    } br_type_e;

endpackage : isa_pkg

// ==== rtl/sdpram.sv ====
`timescale 1ns/1ns

module sdpram #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 48
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] raddr_i,
    input  logic [ADDR_WIDTH-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0] din_i,
    output logic [DATA_WIDTH-1:0] dout_o
);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    // One read port, one write port
    logic [DATA_WIDTH-1:0] mem [1 << ADDR_WIDTH];

    // Write port, no reset on the array
    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            mem[waddr_i] <= din_i;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    // Registered output, samples the array before this edge's write
    // Same address on both ports gives the old word (read-first)
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_o <= '0;
        end else if (en_i) begin
            dout_o <= mem[raddr_i];
        end
    end

endmodule : sdpram

// ==== tb.f ====
rtl/isa_pkg.sv
rtl/btb_pkg.sv
rtl/sdpram.sv
rtl/btb_lookup_gen.sv
rtl/btb_bank.sv
rtl/btb_bank_select.sv
rtl/bpu_btb_top.sv
verif/tb_bpu_btb.sv

// ==== verif/tb_bpu_btb.sv ====
`timescale 1ns/1ns

module tb_bpu_btb;

    logic                clk;
    logic                rst_n;
    logic                update_i;
    isa_pkg::br_type_e   br_type_i;
    isa_pkg::pc_t        rpc_i;
    isa_pkg::pc_t        wpc_i;
    isa_pkg::pc_t        bta_i;
    logic                miss_o;
    btb_pkg::choice_t    choice_o;
    isa_pkg::br_type_e   br_type_o;
    isa_pkg::pc_t        bta_o;

    // Reference BTB keyed by {bank, index}
    // Each record keeps its tag in the entry
    btb_pkg::btb_entry_t model_mem [int];
    string               test_name;
    int                  test_errs;
    int                  tests_run;
    int                  tests_failed;
    int                  total_errs;
    logic                aborted;

    bpu_btb_top dut0 (.*);

    // 20 ns period
    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Reference model, hash rules
    // ------------------------------------------------------------

    // Tag PC[31:17] ^ PC[17:3]
    function automatic btb_pkg::tag_t model_tag(isa_pkg::pc_t pc);
        return pc[31:17] ^ pc[17:3];
    endfunction

    // Bank PC[9] on top of index PC[8:3]
    function automatic int model_key(isa_pkg::pc_t pc);
        return int'({pc[9], pc[8:3]});
    endfunction

    // ------------------------------------------------------------
    // Compare tasks, one per result kind
    // ------------------------------------------------------------

    task automatic compare_pc(string what, isa_pkg::pc_t exp, isa_pkg::pc_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_br_type(string what, isa_pkg::br_type_e exp, isa_pkg::br_type_e act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_choice(string what, btb_pkg::choice_t exp, btb_pkg::choice_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_miss(string what, logic exp, logic act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    // Called 2 ns after an edge; checks the read 1 ns after the next edge
    task automatic issue(isa_pkg::pc_t rpc, logic wr, isa_pkg::pc_t wpc,
                         isa_pkg::pc_t bta, isa_pkg::br_type_e bt);
        btb_pkg::btb_entry_t ent;
        logic                hit;
        logic [31:0]         next_addr;
        isa_pkg::pc_t        exp_bta;
        int                  key;
        key = model_key(rpc);
        hit = model_mem.exists(key) && (model_mem[key].tag == model_tag(rpc));
        if (hit) ent = model_mem[key];
        // Byte address of the next 8-byte block
        next_addr = ({rpc, 2'b00} & 32'hffff_fff8) + 32'd8;
        exp_bta = hit ? ent.bta : next_addr[31:2];
        rpc_i = rpc;
        update_i = wr;
        wpc_i = wpc;
        bta_i = bta;
        br_type_i = bt;
        // Read-first, so the model write lands after the expectation
        if (wr) begin
            model_mem[model_key(wpc)] = '{choice: wpc[2], tag: model_tag(wpc),
                                          bta: bta, br_type: bt};
        end
        @(posedge clk);
        #1;
        compare_miss("miss", !hit, miss_o);
        if (hit) compare_choice("choice", ent.choice, choice_o);
        compare_br_type("br_type", hit ? ent.br_type : isa_pkg::BR_PC_RELATIVE, br_type_o);
        compare_pc("bta", exp_bta, bta_o);
        #1;
        update_i = 1'b0;
    endtask

    task automatic read_only(isa_pkg::pc_t rpc);
        issue(rpc, 1'b0, '0, '0, isa_pkg::BR_PC_RELATIVE);
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errs);
        end
    endtask

    // Miss flag must come up once reset is released
    task automatic wait_reset_idle();
        int n;
        n = 0;
        while (miss_o !== 1'b1 && n < 10) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (miss_o !== 1'b1) begin
            $display("timeout: no miss reported within 10 cycles after reset");
            aborted = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------

    task automatic after_reset_misses();
        start_test("reset_miss");
        repeat (20) read_only(isa_pkg::pc_t'($urandom));
        report_test();
    endtask

    task automatic write_then_hit();
        isa_pkg::pc_t a;
        start_test("write_hit");
        a = isa_pkg::pc_t'($urandom);
        issue(a, 1'b1, a, isa_pkg::pc_t'($urandom), isa_pkg::BR_CALL);
        read_only(a);
        compare_miss("hit", 1'b0, miss_o);
        report_test();
    endtask

    // Bit 25 only feeds the upper tag half, same bank and index
    task automatic tag_conflict();
        isa_pkg::pc_t a;
        isa_pkg::pc_t b;
        start_test("tag_conflict");
        a = isa_pkg::pc_t'($urandom);
        b = a;
        b[25] = ~a[25];
        issue(a, 1'b1, a, isa_pkg::pc_t'($urandom), isa_pkg::BR_ABSOLUTE);
        read_only(b);
        compare_miss("other tag", 1'b1, miss_o);
        issue(b, 1'b1, b, isa_pkg::pc_t'($urandom), isa_pkg::BR_RETURN);
        read_only(a);
        compare_miss("evicted", 1'b1, miss_o);
        read_only(b);
        report_test();
    endtask

    // Bit 9 picks the bank
    task automatic bank_split();
        isa_pkg::pc_t a;
        isa_pkg::pc_t b;
        start_test("bank_split");
        a = isa_pkg::pc_t'($urandom);
        b = a;
        b[9] = ~a[9];
        issue(a, 1'b1, a, isa_pkg::pc_t'($urandom), isa_pkg::BR_CALL);
        issue(b, 1'b1, b, isa_pkg::pc_t'($urandom), isa_pkg::BR_ABSOLUTE);
        read_only(a);
        compare_miss("bank a", 1'b0, miss_o);
        read_only(b);
        compare_miss("bank b", 1'b0, miss_o);
        report_test();
    endtask

    // Slot bit flipped on the second write, so the new choice differs
    task automatic read_write_collision();
        isa_pkg::pc_t a;
        isa_pkg::pc_t a2;
        start_test("read_first");
        a = isa_pkg::pc_t'($urandom);
        a2 = a;
        a2[2] = ~a[2];
        issue(a, 1'b1, a, isa_pkg::pc_t'($urandom), isa_pkg::BR_ABSOLUTE);
        issue(a, 1'b1, a2, isa_pkg::pc_t'($urandom), isa_pkg::BR_RETURN);
        read_only(a);
        report_test();
    endtask

    // Small PC pool, upper half aliases the lower half's slots
    task automatic random_stream();
        isa_pkg::pc_t pool [8];
        start_test("random_stream");
        for (int i = 0; i < 4; i++) begin
            pool[i] = isa_pkg::pc_t'($urandom);
            pool[i+4] = pool[i];
            pool[i+4][25] = ~pool[i][25];
        end
        repeat (200) begin
            issue(pool[$urandom_range(7, 0)], 1'($urandom_range(1, 0)),
                  pool[$urandom_range(7, 0)], isa_pkg::pc_t'($urandom),
                  isa_pkg::br_type_e'($urandom_range(3, 0)));
        end
        report_test();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        update_i = 1'b0;
        br_type_i = isa_pkg::BR_PC_RELATIVE;
        rpc_i = '0;
        wpc_i = '0;
        bta_i = '0;
        tests_run = 0;
        tests_failed = 0;
        total_errs = 0;
        aborted = 1'b0;
        void'($urandom(32'h6753c42b));
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait_reset_idle();
        if (!aborted) begin
            after_reset_misses();
            write_then_hit();
            tag_conflict();
            bank_split();
            read_write_collision();
            random_stream();
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
        if (!aborted && total_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_bpu_btb
